// File: include/state_cache_cfg.svh
`ifndef STATE_CACHE_CFG_SVH
`define STATE_CACHE_CFG_SVH

// Flow key width in bits
`define SC_KEY_W 16

// Number of state IDs and the ID width
`define SC_NUM_IDS 16
`define SC_ID_W 4

// Statistics counter width
`define SC_CNT_W 32

`endif

// File: verilog/state_cache_pkg.sv
`default_nettype none

`include "state_cache_cfg.svh"

package state_cache_pkg;

    // ------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------
    typedef logic [`SC_KEY_W-1:0]   key_t;
    typedef logic [`SC_ID_W-1:0]    id_t;
    typedef logic [`SC_NUM_IDS-1:0] id_mask_t;
    typedef logic [`SC_CNT_W-1:0]   cnt_t;

    // ------------------------------------------------------------
    // Structs
    // ------------------------------------------------------------
    // Lookup outcome, also used as the counter event
    typedef struct packed {
        logic tracked;
        logic is_new;
        id_t  id;
    } lookup_result_t;

    // Insert into the key table
    typedef struct packed {
        id_t  id;
        key_t key;
    } table_write_t;

    // Delete response; err set when the ID was not in use
    typedef struct packed {
        logic err;
        key_t key;
    } delete_resp_t;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        READ    = 2'd1,
        CLEAR   = 2'd2,
        RESPOND = 2'd3
    } delete_state_t;

endpackage : state_cache_pkg

`default_nettype wire

// File: verilog/key_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "state_cache_cfg.svh"

module key_table (
    input  wire                           clk,
    input  wire                           htable_srst,
    input  wire state_cache_pkg::key_t    i_search_key,
    output logic                          o_hit,
    output state_cache_pkg::id_t          o_hit_id,
    input  wire                           i_insert_valid,
    input  wire state_cache_pkg::table_write_t i_insert,
    input  wire                           i_clear_valid,
    input  wire state_cache_pkg::id_t     i_clear_id,
    input  wire state_cache_pkg::id_t     i_read_id,
    output state_cache_pkg::key_t         o_read_key,
    output logic                          o_read_valid
);

    import state_cache_pkg::*;

    key_t     keys [`SC_NUM_IDS];
    id_mask_t valid;

    // Associative search, lowest matching ID wins
    always_comb begin
        o_hit    = 1'b0;
        o_hit_id = '0;
        for (int i = 0; i < `SC_NUM_IDS; i++) begin
            if (!o_hit && valid[i] && (keys[i] == i_search_key)) begin
                o_hit    = 1'b1;
                o_hit_id = id_t'(i);
            end
        end
    end

    // Valid bits
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            valid <= '0;
        end else begin
            if (i_insert_valid) begin
                valid[i_insert.id] <= 1'b1;
            end
            if (i_clear_valid) begin
                valid[i_clear_id] <= 1'b0;
            end
        end
    end

    // Key storage
    always_ff @(posedge clk) begin
        if (i_insert_valid) begin
            keys[i_insert.id] <= i_insert.key;
        end
    end

    assign o_read_key   = keys[i_read_id];
    assign o_read_valid = valid[i_read_id];

    assert property (@(posedge clk) disable iff (htable_srst)
        i_insert_valid |-> !valid[i_insert.id]);

endmodule : key_table

`default_nettype wire

// File: verilog/id_allocator.sv
`timescale 1ns/1ps
`default_nettype none

`include "state_cache_cfg.svh"

module id_allocator (
    input  wire                       clk,
    input  wire                       htable_srst,
    output logic                      o_free_valid,
    output state_cache_pkg::id_t      o_free_id,
    input  wire                       i_take,
    input  wire                       i_release_valid,
    input  wire state_cache_pkg::id_t i_release_id
);

    import state_cache_pkg::*;

    id_mask_t free_ids;
    id_mask_t free_nxt;

    // ------------------------------------------------------------
    // Lowest free ID
    // ------------------------------------------------------------
    always_comb begin
        o_free_id = '0;
        for (int i = `SC_NUM_IDS - 1; i >= 0; i--) begin
            if (free_ids[i]) begin
                o_free_id = id_t'(i);
            end
        end
    end

    assign o_free_valid = |free_ids;

    // ------------------------------------------------------------
    // Free vector update
    // ------------------------------------------------------------
    always_comb begin
        free_nxt = free_ids;
        if (i_take) begin
            free_nxt[o_free_id] = 1'b0;
        end
        // Release and take may land in the same cycle
        if (i_release_valid) begin
            free_nxt[i_release_id] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (htable_srst) begin
            free_ids <= '1;
        end else begin
            free_ids <= free_nxt;
        end
    end

    assert property (@(posedge clk) disable iff (htable_srst)
        i_release_valid |-> !free_ids[i_release_id]);

endmodule : id_allocator

`default_nettype wire

// File: verilog/lookup_stage.sv
`timescale 1ns/1ps
`default_nettype none

module lookup_stage (
    input  wire                             clk,
    input  wire                             htable_srst,
    input  wire                             i_lookup_valid,
    input  wire state_cache_pkg::key_t      i_lookup_key,
    output logic                            o_lookup_ready,
    output logic                            o_result_valid,
    output state_cache_pkg::lookup_result_t o_result,
    input  wire                             i_result_ready,
    input  wire                             i_hold,
    output state_cache_pkg::key_t           o_search_key,
    input  wire                             i_hit,
    input  wire state_cache_pkg::id_t       i_hit_id,
    input  wire                             i_free_valid,
    input  wire state_cache_pkg::id_t       i_free_id,
    output logic                            o_alloc_take,
    output logic                            o_insert_valid,
    output state_cache_pkg::table_write_t   o_insert,
    output logic                            o_event_valid,
    output state_cache_pkg::lookup_result_t o_event
);

    import state_cache_pkg::*;

    logic           accept;
    lookup_result_t next_result;

    // Stall while a delete runs or a result waits for the client
    assign o_lookup_ready = !i_hold && (!o_result_valid || i_result_ready);
    assign accept         = i_lookup_valid && o_lookup_ready;

    // Search uses the presented key, resolved in the same cycle
    assign o_search_key = i_lookup_key;

    // ------------------------------------------------------------
    // Decision: hit, insert or not tracked
    // ------------------------------------------------------------
    always_comb begin
        next_result = '0;
        if (i_hit) begin
            next_result.tracked = 1'b1;
            next_result.id      = i_hit_id;
        end else if (i_free_valid) begin
            next_result.tracked = 1'b1;
            next_result.is_new  = 1'b1;
            next_result.id      = i_free_id;
        end
    end

    // Auto-insert on a miss when an ID is on offer
    assign o_alloc_take   = accept && !i_hit && i_free_valid;
    assign o_insert_valid = o_alloc_take;
    assign o_insert.id    = i_free_id;
    assign o_insert.key   = i_lookup_key;

    assign o_event_valid = accept;
    assign o_event       = next_result;

    // ------------------------------------------------------------
    // Result register
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            o_result_valid <= 1'b0;
        end else if (accept) begin
            o_result_valid <= 1'b1;
        end else if (i_result_ready) begin
            o_result_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_result <= next_result;
        end
    end

    // A waiting result holds still until the client takes it
    assert property (@(posedge clk) disable iff (htable_srst)
        o_result_valid && !i_result_ready |=> o_result_valid && $stable(o_result));

endmodule : lookup_stage

`default_nettype wire

// File: verilog/delete_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module delete_fsm (
    input  wire                           clk,
    input  wire                           htable_srst,
    input  wire                           i_delete_valid,
    input  wire state_cache_pkg::id_t     i_delete_id,
    output logic                          o_delete_ready,
    output logic                          o_delete_resp_valid,
    output state_cache_pkg::delete_resp_t o_delete_resp,
    input  wire                           i_delete_resp_ready,
    output logic                          o_busy,
    output state_cache_pkg::id_t          o_read_id,
    input  wire state_cache_pkg::key_t    i_read_key,
    input  wire                           i_read_valid,
    output logic                          o_clear_valid,
    output state_cache_pkg::id_t          o_clear_id,
    output logic                          o_release_valid,
    output state_cache_pkg::id_t          o_release_id
);

    import state_cache_pkg::*;

    delete_state_t state;
    delete_state_t state_nxt;

    id_t  del_id;
    key_t del_key;
    logic del_valid;

    // ------------------------------------------------------------
    // State register and next state
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (i_delete_valid) state_nxt = READ;
            READ:    state_nxt = CLEAR;
            CLEAR:   state_nxt = RESPOND;
            RESPOND: if (i_delete_resp_ready) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // ------------------------------------------------------------
    // Context
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (state == IDLE && i_delete_valid) begin
            del_id <= i_delete_id;
        end
        if (state == READ) begin
            del_key   <= i_read_key;
            del_valid <= i_read_valid;
        end
    end

    assign o_delete_ready = (state == IDLE);
    assign o_busy         = (state != IDLE);
    assign o_read_id      = del_id;

    // Clear and release only an entry that was in use
    assign o_clear_valid   = (state == CLEAR) && del_valid;
    assign o_clear_id      = del_id;
    assign o_release_valid = o_clear_valid;
    assign o_release_id    = del_id;

    assign o_delete_resp_valid = (state == RESPOND);
    assign o_delete_resp.err   = !del_valid;
    assign o_delete_resp.key   = del_key;

    // Response holds until the client takes it
    assert property (@(posedge clk) disable iff (htable_srst)
        o_delete_resp_valid && !i_delete_resp_ready
        |=> o_delete_resp_valid && $stable(o_delete_resp));

endmodule : delete_fsm

`default_nettype wire

// File: verilog/stat_counters.sv
`timescale 1ns/1ps
`default_nettype none

module stat_counters (
    input  wire                             clk,
    input  wire                             htable_srst,
    input  wire                             i_event_valid,
    input  wire state_cache_pkg::lookup_result_t i_event,
    input  wire                             i_cnt_clear,
    output state_cache_pkg::cnt_t           o_cnt_req,
    output state_cache_pkg::cnt_t           o_cnt_existing,
    output state_cache_pkg::cnt_t           o_cnt_new,
    output state_cache_pkg::cnt_t           o_cnt_not_tracked
);

    import state_cache_pkg::*;

    logic           ev_valid;
    lookup_result_t ev;
    logic [3:0]     inc;
    cnt_t           cnt [4];

    // Register the event first
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            ev_valid <= 1'b0;
        end else begin
            ev_valid <= i_event_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_event_valid) begin
            ev <= i_event;
        end
    end

    // Request count plus exactly one class
    assign inc[0] = ev_valid;
    assign inc[1] = ev_valid && ev.tracked && !ev.is_new;
    assign inc[2] = ev_valid && ev.tracked && ev.is_new;
    assign inc[3] = ev_valid && !ev.tracked;

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (htable_srst || i_cnt_clear) begin
                cnt[i] <= '0;
            end else if (inc[i]) begin
                cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end

    assign o_cnt_req         = cnt[0];
    assign o_cnt_existing    = cnt[1];
    assign o_cnt_new         = cnt[2];
    assign o_cnt_not_tracked = cnt[3];

endmodule : stat_counters

`default_nettype wire

// File: verilog/state_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module state_cache_top (
    input  wire                            clk,
    input  wire                            htable_srst,

    // Lookup request and result
    input  wire                            i_lookup_valid,
    input  wire state_cache_pkg::key_t     i_lookup_key,
    output logic                           o_lookup_ready,
    output logic                           o_result_valid,
    output state_cache_pkg::lookup_result_t o_result,
    input  wire                            i_result_ready,

    // Delete request and response
    input  wire                            i_delete_valid,
    input  wire state_cache_pkg::id_t      i_delete_id,
    output logic                           o_delete_ready,
    output logic                           o_delete_resp_valid,
    output state_cache_pkg::delete_resp_t  o_delete_resp,
    input  wire                            i_delete_resp_ready,

    // Statistics
    input  wire                            i_cnt_clear,
    output state_cache_pkg::cnt_t          o_cnt_req,
    output state_cache_pkg::cnt_t          o_cnt_existing,
    output state_cache_pkg::cnt_t          o_cnt_new,
    output state_cache_pkg::cnt_t          o_cnt_not_tracked
);

    import state_cache_pkg::*;

    // ------------------------------------------------------------
    // Internal wiring
    // ------------------------------------------------------------
    key_t           search_key;
    logic           hit;
    id_t            hit_id;

    logic           free_valid;
    id_t            free_id;
    logic           alloc_take;

    logic           insert_valid;
    table_write_t   insert;

    logic           busy;
    id_t            read_id;
    key_t           read_key;
    logic           read_valid;
    logic           clear_valid;
    id_t            clear_id;
    logic           release_valid;
    id_t            release_id;

    logic           event_valid;
    lookup_result_t event_data;

    // ------------------------------------------------------------
    // Lookup path
    // ------------------------------------------------------------
    lookup_stage u_lookup_stage (
        .clk            (clk),
        .htable_srst    (htable_srst),
        .i_lookup_valid (i_lookup_valid),
        .i_lookup_key   (i_lookup_key),
        .o_lookup_ready (o_lookup_ready),
        .o_result_valid (o_result_valid),
        .o_result       (o_result),
        .i_result_ready (i_result_ready),
        .i_hold         (busy),
        .o_search_key   (search_key),
        .i_hit          (hit),
        .i_hit_id       (hit_id),
        .i_free_valid   (free_valid),
        .i_free_id      (free_id),
        .o_alloc_take   (alloc_take),
        .o_insert_valid (insert_valid),
        .o_insert       (insert),
        .o_event_valid  (event_valid),
        .o_event        (event_data)
    );

    key_table u_key_table (
        .clk            (clk),
        .htable_srst    (htable_srst),
        .i_search_key   (search_key),
        .o_hit          (hit),
        .o_hit_id       (hit_id),
        .i_insert_valid (insert_valid),
        .i_insert       (insert),
        .i_clear_valid  (clear_valid),
        .i_clear_id     (clear_id),
        .i_read_id      (read_id),
        .o_read_key     (read_key),
        .o_read_valid   (read_valid)
    );

    id_allocator u_id_allocator (
        .clk             (clk),
        .htable_srst     (htable_srst),
        .o_free_valid    (free_valid),
        .o_free_id       (free_id),
        .i_take          (alloc_take),
        .i_release_valid (release_valid),
        .i_release_id    (release_id)
    );

    // ------------------------------------------------------------
    // Delete path and statistics
    // ------------------------------------------------------------
    delete_fsm u_delete_fsm (
        .clk                 (clk),
        .htable_srst         (htable_srst),
        .i_delete_valid      (i_delete_valid),
        .i_delete_id         (i_delete_id),
        .o_delete_ready      (o_delete_ready),
        .o_delete_resp_valid (o_delete_resp_valid),
        .o_delete_resp       (o_delete_resp),
        .i_delete_resp_ready (i_delete_resp_ready),
        .o_busy              (busy),
        .o_read_id           (read_id),
        .i_read_key          (read_key),
        .i_read_valid        (read_valid),
        .o_clear_valid       (clear_valid),
        .o_clear_id          (clear_id),
        .o_release_valid     (release_valid),
        .o_release_id        (release_id)
    );

    stat_counters u_stat_counters (
        .clk               (clk),
        .htable_srst       (htable_srst),
        .i_event_valid     (event_valid),
        .i_event           (event_data),
        .i_cnt_clear       (i_cnt_clear),
        .o_cnt_req         (o_cnt_req),
        .o_cnt_existing    (o_cnt_existing),
        .o_cnt_new         (o_cnt_new),
        .o_cnt_not_tracked (o_cnt_not_tracked)
    );

endmodule : state_cache_top

`default_nettype wire

// File: sim/tb_state_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "state_cache_cfg.svh"

module tb_state_cache;

    import state_cache_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    logic           clk;
    logic           htable_srst;
    logic           i_lookup_valid;
    key_t           i_lookup_key;
    logic           o_lookup_ready;
    logic           o_result_valid;
    lookup_result_t o_result;
    logic           i_result_ready;
    logic           i_delete_valid;
    id_t            i_delete_id;
    logic           o_delete_ready;
    logic           o_delete_resp_valid;
    delete_resp_t   o_delete_resp;
    logic           i_delete_resp_ready;
    logic           i_cnt_clear;
    cnt_t           o_cnt_req;
    cnt_t           o_cnt_existing;
    cnt_t           o_cnt_new;
    cnt_t           o_cnt_not_tracked;

    // Reference model state
    key_t mdl_key [`SC_NUM_IDS];
    logic mdl_valid [`SC_NUM_IDS];
    logic mdl_free [`SC_NUM_IDS];
    cnt_t mdl_req;
    cnt_t mdl_existing;
    cnt_t mdl_new;
    cnt_t mdl_not_tracked;

    // Expected responses in acceptance order
    lookup_result_t exp_results [$];
    delete_resp_t   exp_deletes [$];
    lookup_result_t exp_res;
    delete_resp_t   exp_del;
    lookup_result_t held_result;

    int          err_count;
    int          test_num;
    int          tests_failed;
    int          test_start_errs;
    logic        timed_out;
    integer      seed;
    integer      pick;
    logic [7:0]  key_idx;

    state_cache_top state_cache_top_inst (
        .clk                 (clk),
        .htable_srst         (htable_srst),
        .i_lookup_valid      (i_lookup_valid),
        .i_lookup_key        (i_lookup_key),
        .o_lookup_ready      (o_lookup_ready),
        .o_result_valid      (o_result_valid),
        .o_result            (o_result),
        .i_result_ready      (i_result_ready),
        .i_delete_valid      (i_delete_valid),
        .i_delete_id         (i_delete_id),
        .o_delete_ready      (o_delete_ready),
        .o_delete_resp_valid (o_delete_resp_valid),
        .o_delete_resp       (o_delete_resp),
        .i_delete_resp_ready (i_delete_resp_ready),
        .i_cnt_clear         (i_cnt_clear),
        .o_cnt_req           (o_cnt_req),
        .o_cnt_existing      (o_cnt_existing),
        .o_cnt_new           (o_cnt_new),
        .o_cnt_not_tracked   (o_cnt_not_tracked)
    );

    always #2 clk = ~clk;

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic lookup_result_t model_lookup(input key_t key);
        lookup_result_t res;
        int             free_idx;
        res      = '0;
        free_idx = -1;
        for (int i = 0; i < `SC_NUM_IDS; i++) begin
            if (!res.tracked && mdl_valid[i] && mdl_key[i] == key) begin
                res.tracked = 1'b1;
                res.id      = id_t'(i);
            end
        end
        if (!res.tracked) begin
            // Lowest free ID gets the new key
            for (int i = `SC_NUM_IDS - 1; i >= 0; i--) begin
                if (mdl_free[i]) free_idx = i;
            end
            if (free_idx >= 0) begin
                res.tracked         = 1'b1;
                res.is_new          = 1'b1;
                res.id              = id_t'(free_idx);
                mdl_key[free_idx]   = key;
                mdl_valid[free_idx] = 1'b1;
                mdl_free[free_idx]  = 1'b0;
            end
        end
        mdl_req = mdl_req + 1;
        if (!res.tracked) mdl_not_tracked = mdl_not_tracked + 1;
        else if (res.is_new) mdl_new = mdl_new + 1;
        else mdl_existing = mdl_existing + 1;
        return res;
    endfunction

    function automatic delete_resp_t model_delete(input id_t id);
        delete_resp_t res;
        res.err = !mdl_valid[id];
        res.key = mdl_key[id];
        if (mdl_valid[id]) begin
            mdl_valid[id] = 1'b0;
            mdl_free[id]  = 1'b1;
        end
        return res;
    endfunction

    // ------------------------------------------------------------
    // Compare process
    // ------------------------------------------------------------
    always @(posedge clk) begin
        if (!htable_srst && o_result_valid && i_result_ready) begin
            if (exp_results.size() == 0) begin
                $display("Lookup result arrived with no lookup outstanding");
                err_count++;
            end else begin
                exp_res = exp_results.pop_front();
                if (o_result !== exp_res) begin
                    $display("Error: o_result got %h expected %h", o_result, exp_res);
                    err_count++;
                end
            end
        end
        if (!htable_srst && o_delete_resp_valid && i_delete_resp_ready) begin
            if (exp_deletes.size() == 0) begin
                $display("Delete response arrived with no delete outstanding");
                err_count++;
            end else begin
                exp_del = exp_deletes.pop_front();
                // Key only means something for a valid entry
                if (o_delete_resp.err !== exp_del.err) begin
                    $display("Error: o_delete_resp.err got %h expected %h",
                             o_delete_resp.err, exp_del.err);
                    err_count++;
                end else if (!exp_del.err && o_delete_resp.key !== exp_del.key) begin
                    $display("Error: o_delete_resp.key got %h expected %h",
                             o_delete_resp.key, exp_del.key);
                    err_count++;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------
    task automatic report_timeout(input string what);
        $display("Timeout: no %s within %0d cycles", what, TIMEOUT_CYCLES);
        timed_out = 1'b1;
        err_count++;
    endtask

    // Called on a falling edge with the lookup already driven
    task automatic wait_lookup_accept(input key_t key);
        int cycles;
        cycles = 0;
        #1;
        while (!o_lookup_ready && !timed_out) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("lookup ready");
            end else begin
                @(negedge clk);
                #1;
            end
        end
        if (!timed_out) begin
            exp_results.push_back(model_lookup(key));
        end
        @(negedge clk);
        i_lookup_valid = 1'b0;
    endtask

    task automatic send_lookup(input key_t key);
        @(negedge clk);
        i_lookup_valid = 1'b1;
        i_lookup_key   = key;
        wait_lookup_accept(key);
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while ((exp_results.size() != 0 || exp_deletes.size() != 0) && !timed_out) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("outstanding response");
            end else begin
                @(negedge clk);
            end
        end
    endtask

    task automatic send_delete(input id_t id);
        int cycles;
        @(negedge clk);
        i_delete_valid = 1'b1;
        i_delete_id    = id;
        cycles = 0;
        #1;
        while (!o_delete_ready && !timed_out) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("delete ready");
            end else begin
                @(negedge clk);
                #1;
            end
        end
        if (!timed_out) begin
            exp_deletes.push_back(model_delete(id));
        end
        @(negedge clk);
        i_delete_valid = 1'b0;
        wait_drained();
    endtask

    task automatic wait_result_valid();
        int cycles;
        cycles = 0;
        #1;
        while (!o_result_valid && !timed_out) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("lookup result");
            end else begin
                @(negedge clk);
                #1;
            end
        end
    endtask

    task automatic check_counter(input string name, input cnt_t got, input cnt_t exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (err_count == test_start_errs) begin
            $display("Test %0d %s: passed", test_num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", test_num, name,
                     err_count - test_start_errs);
        end
        test_start_errs = err_count;
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        clk                 = 1'b0;
        htable_srst         = 1'b1;
        i_lookup_valid      = 1'b0;
        i_lookup_key        = '0;
        i_result_ready      = 1'b1;
        i_delete_valid      = 1'b0;
        i_delete_id         = '0;
        i_delete_resp_ready = 1'b1;
        i_cnt_clear         = 1'b0;
        err_count           = 0;
        test_num            = 0;
        tests_failed        = 0;
        test_start_errs     = 0;
        timed_out           = 1'b0;
        seed                = 23;
        mdl_req             = '0;
        mdl_existing        = '0;
        mdl_new             = '0;
        mdl_not_tracked     = '0;
        for (int i = 0; i < `SC_NUM_IDS; i++) begin
            mdl_key[i]   = '0;
            mdl_valid[i] = 1'b0;
            mdl_free[i]  = 1'b1;
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        htable_srst = 1'b0;

        // Distinct keys fill IDs from zero, then one repeat
        for (int i = 0; i < 6; i++) send_lookup(16'h1100 + key_t'(i));
        send_lookup(16'h1102);
        wait_drained();
        end_test("new keys");

        for (int i = 6; i < `SC_NUM_IDS; i++) send_lookup(16'h1100 + key_t'(i));
        send_lookup(16'h2222);
        send_lookup(16'h1109);
        wait_drained();
        end_test("table full");

        send_delete(4'd3);
        send_delete(4'd7);
        send_lookup(16'h1107);
        send_delete(4'd7);
        send_delete(4'd7);
        send_lookup(16'h1103);
        wait_drained();
        end_test("delete");

        // Result held back while a second lookup waits
        @(negedge clk);
        i_result_ready = 1'b0;
        send_lookup(16'h1100);
        wait_result_valid();
        held_result = exp_results[0];
        @(negedge clk);
        i_lookup_valid = 1'b1;
        i_lookup_key   = 16'h2345;
        repeat (5) begin
            #1;
            if (o_lookup_ready !== 1'b0) begin
                $display("Error: o_lookup_ready got %h expected %h", o_lookup_ready, 1'b0);
                err_count++;
            end
            if (o_result !== held_result) begin
                $display("Error: o_result got %h expected %h", o_result, held_result);
                err_count++;
            end
            @(negedge clk);
        end
        i_result_ready = 1'b1;
        wait_lookup_accept(16'h2345);
        wait_drained();
        end_test("back-pressure");

        // Random mix over a small key pool so that keys repeat
        for (int n = 0; n < 60; n++) begin
            pick = $random(seed);
            if (pick[1:0] == 2'd0) begin
                send_delete(pick[7:4]);
            end else begin
                key_idx = pick[15:8] % 8'd24;
                send_lookup({8'h11, key_idx});
            end
        end
        wait_drained();
        // Counters trail the event by a registered stage
        repeat (3) @(negedge clk);
        #1;
        check_counter("o_cnt_req", o_cnt_req, mdl_req);
        check_counter("o_cnt_existing", o_cnt_existing, mdl_existing);
        check_counter("o_cnt_new", o_cnt_new, mdl_new);
        check_counter("o_cnt_not_tracked", o_cnt_not_tracked, mdl_not_tracked);
        @(negedge clk);
        i_cnt_clear = 1'b1;
        @(negedge clk);
        i_cnt_clear = 1'b0;
        #1;
        check_counter("o_cnt_req", o_cnt_req, '0);
        check_counter("o_cnt_existing", o_cnt_existing, '0);
        check_counter("o_cnt_new", o_cnt_new, '0);
        check_counter("o_cnt_not_tracked", o_cnt_not_tracked, '0);
        end_test("counters");

        $display("Tests run: %0d, failed: %0d, errors: %0d", test_num, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : tb_state_cache

`default_nettype wire

// File: verilog.f
+incdir+include
verilog/state_cache_pkg.sv
verilog/key_table.sv
verilog/id_allocator.sv
verilog/lookup_stage.sv
verilog/delete_fsm.sv
verilog/stat_counters.sv
verilog/state_cache_top.sv
sim/tb_state_cache.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/1ps \
    --top-module tb_state_cache \
    --Mdir obj_dir -o tb_state_cache \
    -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_state_cache)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1
